// File: source/exe_settings.svh
// Execute stage settings
// Widths and constants shared by the package and the RTL
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

`define EXE_XLEN         32    // Register width
`define EXE_PC_SZ        32    // Program counter width
`define EXE_GPR_ASZ      5     // Register address width, 32 registers
`define EXE_OP_SZ        4     // Opcode field from decode

// Size of one instruction
// Sets the link address and the fall-through address
`define EXE_INSTR_BYTES  4

`endif

// File: source/exe_pkg.sv
// Execute stage package
// Word and address types, instruction kinds and the shared opcode word
`include "exe_settings.svh"

package exe_pkg;

   typedef logic [`EXE_XLEN-1:0]    word_t;      // One data word
   typedef logic [`EXE_PC_SZ-1:0]   pc_t;        // Code address
   typedef logic [`EXE_GPR_ASZ-1:0] gpr_addr_t;  // Register number

   // Which unit result the stage passes on
   typedef enum logic [2:0]
   {
      ALU, BRANCH, LOAD, STORE, ILLEGAL
   } instr_kind_t;

   // ----------------------------------------------------------------------
   // Opcode encodings, one per unit
   typedef enum logic [`EXE_OP_SZ-1:0]
   {
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI
   } alu_op_t;

   typedef enum logic [`EXE_OP_SZ-1:0]
   {
      B_ADD,                              // Conditional branch, pc + imm
      B_JAL,
      B_JALR
   } br_op_t;

   // Decode sends one opcode word, the kind says which view applies
   typedef union packed
   {
      alu_op_t alu;
      br_op_t  br;
   } op_code_u;

   // Load/store access size, from funct3[1:0]
   typedef enum logic [1:0] {BYTE, HALF, WORD} ls_size_t;

endpackage

// File: source/exe_operand_if.sv
// Operand bus
// Forwarded register operands and decoded fields, fed to the ALU and address units
`timescale 1ns/10ps

interface exe_operand_if import exe_pkg::*; ();

   word_t      rs1;          // Rs1 after forwarding
   word_t      rs2;          // Rs2 after forwarding
   pc_t        pc;           // Address of this instruction
   word_t      imm;          // Sign extended immediate
   logic       sel_imm;      // 1 = imm as second ALU operand
   op_code_u   op;
   logic [2:0] funct3;

   // Driven by the forwarding block
   modport src (output rs1, rs2, pc, imm, sel_imm, op, funct3);

   // Read by both units
   modport dst (input rs1, rs2, pc, imm, sel_imm, op, funct3);

endinterface

// File: source/exe_addr_if.sv
// Address unit result bus
// Branch target, link address and load/store access fields
`timescale 1ns/10ps

interface exe_addr_if import exe_pkg::*; ();

   pc_t      next_pc;        // Resolved address of the next instruction
   pc_t      link_pc;        // Fall-through address, Rd value for JAL/JALR
   logic     br_mis;         // Target not on a 4 byte boundary
   word_t    ls_addr;        // Effective load/store address
   word_t    st_data;
   ls_size_t size;
   logic     zero_ext;       // LBU, LHU
   logic     ls_mis;         // Misaligned half or word access

   modport src (output next_pc, link_pc, br_mis, ls_addr, st_data, size, zero_ext,
                       ls_mis);

   modport dst (input  next_pc, link_pc, br_mis, ls_addr, st_data, size, zero_ext,
                       ls_mis);

endinterface

// File: source/exe_operand_fwd.sv
// Operand forwarding
// Picks Rs1/Rs2 from the MEM stage, the WB stage or the register file, MEM first,
// then drives the operand bus together with the decoded fields
`timescale 1ns/10ps

module exe_operand_fwd import exe_pkg::*;
(
   input  gpr_addr_t   rs1_addr,
   input  gpr_addr_t   rs2_addr,
   input  logic        rs1_rd,             // Instruction reads Rs1
   input  logic        rs2_rd,
   input  word_t       gpr_rs1_data,       // Register file read data
   input  word_t       gpr_rs2_data,

   input  logic        fwd_mem_valid,
   input  logic        fwd_mem_rd_wr,
   input  gpr_addr_t   fwd_mem_rd_addr,
   input  word_t       fwd_mem_rd_data,
   input  logic        fwd_wb_valid,
   input  logic        fwd_wb_rd_wr,
   input  gpr_addr_t   fwd_wb_rd_addr,
   input  word_t       fwd_wb_rd_data,

   input  pc_t         pc,
   input  word_t       imm,
   input  logic        sel_imm,
   input  op_code_u    op,
   input  logic [2:0]  funct3,

   exe_operand_if.src  opnd
);

   // One source register, newest value wins
   function automatic word_t fwd_pick
   (
      input logic      rd_en,
      input gpr_addr_t addr,
      input word_t     rf_data
   );
      logic use_fwd;
      use_fwd = rd_en & (addr != '0);                  // x0 is never forwarded
      if (use_fwd & fwd_mem_valid & fwd_mem_rd_wr & (addr == fwd_mem_rd_addr))
         return fwd_mem_rd_data;
      else if (use_fwd & fwd_wb_valid & fwd_wb_rd_wr & (addr == fwd_wb_rd_addr))
         return fwd_wb_rd_data;
      return rf_data;                                  // Register file copy is current
   endfunction

   always_comb
   begin
      opnd.rs1     = fwd_pick(rs1_rd, rs1_addr, gpr_rs1_data);
      opnd.rs2     = fwd_pick(rs2_rd, rs2_addr, gpr_rs2_data);
      opnd.pc      = pc;
      opnd.imm     = imm;
      opnd.sel_imm = sel_imm;
      opnd.op      = op;
      opnd.funct3  = funct3;
   end

endmodule

// File: source/exe_alu_unit.sv
// Integer ALU
// Single cycle RV32I register and immediate operations
`timescale 1ns/10ps

module exe_alu_unit import exe_pkg::*;
(
   exe_operand_if.dst opnd,
   output word_t      alu_result
);

   word_t      op_a;
   word_t      op_b;
   logic [4:0] shamt;

   assign op_a  = opnd.rs1;
   assign op_b  = opnd.sel_imm ? opnd.imm : opnd.rs2;  // I-type or R-type
   assign shamt = op_b[4:0];                          // Only 5 bits count for RV32

   // ----------------------------------------------------------------------
   always_comb
   begin
      case (opnd.op.alu)
         ADD:     alu_result = op_a + op_b;
         SUB:     alu_result = op_a - op_b;
         SLL:     alu_result = op_a << shamt;
         SLT:     alu_result = word_t'($signed(op_a) < $signed(op_b));
         SLTU:    alu_result = word_t'(op_a < op_b);
         XOR:     alu_result = op_a ^ op_b;
         SRL:     alu_result = op_a >> shamt;
         SRA:     alu_result = word_t'($signed(op_a) >>> shamt);  // Keeps sign bit
         OR:      alu_result = op_a | op_b;
         AND:     alu_result = op_a & op_b;
         // Decode has already shifted the upper immediate
         LUI:     alu_result = opnd.imm;
         default: alu_result = '0;
      endcase
   end

endmodule

// File: source/exe_addr_unit.sv
// Address unit
// Resolves conditional branches, JAL and JALR, and forms load/store addresses
`timescale 1ns/10ps

`include "exe_settings.svh"

module exe_addr_unit import exe_pkg::*;
(
   exe_operand_if.dst opnd,
   input  instr_kind_t kind,
   exe_addr_if.src    res
);

   pc_t   seq_pc;            // pc + 4
   pc_t   tgt_pc;            // pc + imm
   pc_t   jalr_pc;
   pc_t   next_pc;
   word_t ea;                // Load/store effective address
   logic  taken;

   assign seq_pc  = opnd.pc + pc_t'(`EXE_INSTR_BYTES);
   assign tgt_pc  = opnd.pc + pc_t'(opnd.imm);
   assign jalr_pc = pc_t'(opnd.rs1 + opnd.imm) & ~pc_t'(1);  // Bit 0 dropped per spec

   // ----------------------------------------------------------------------
   // Branch condition from funct3
   always_comb
   begin
      case (opnd.funct3)
         3'b000:  taken = (opnd.rs1 == opnd.rs2);                    // BEQ
         3'b001:  taken = (opnd.rs1 != opnd.rs2);                    // BNE
         3'b100:  taken = ($signed(opnd.rs1) <  $signed(opnd.rs2));  // BLT
         3'b101:  taken = ($signed(opnd.rs1) >= $signed(opnd.rs2));  // BGE
         3'b110:  taken = (opnd.rs1 <  opnd.rs2);                    // BLTU
         3'b111:  taken = (opnd.rs1 >= opnd.rs2);                    // BGEU
         default: taken = 1'b0;
      endcase

      next_pc = seq_pc;                               // Not a branch, falls through
      if (kind == BRANCH)
      begin
         case (opnd.op.br)
            B_JAL:   next_pc = tgt_pc;
            B_JALR:  next_pc = jalr_pc;
            default: next_pc = taken ? tgt_pc : seq_pc;
         endcase
      end
   end

   assign res.next_pc = next_pc;
   assign res.link_pc = seq_pc;
   assign res.br_mis  = (kind == BRANCH) & (next_pc[1:0] != 2'b00);

   // ----------------------------------------------------------------------
   // Load/store
   assign ea           = opnd.rs1 + opnd.imm;
   assign res.ls_addr  = ea;
   assign res.st_data  = opnd.rs2;
   assign res.zero_ext = (kind == LOAD) & opnd.funct3[2];   // LBU, LHU

   always_comb
   begin
      case (opnd.funct3[1:0])
         2'b00:   res.size = BYTE;
         2'b01:   res.size = HALF;
         default: res.size = WORD;
      endcase
      res.ls_mis = ((kind == LOAD) | (kind == STORE)) &
                   (((res.size == HALF) & ea[0]) |
                    ((res.size == WORD) & (ea[1:0] != 2'b00)));
   end

endmodule

// File: source/exe_result_sel.sv
// Result stage
// Merges unit results by kind, raises the PC reload, runs the valid/ready handshake
// and holds the EXE to MEM pipe register
`timescale 1ns/10ps

module exe_result_sel import exe_pkg::*;
(
   input  logic        clk_in,
   input  logic        rst_n,
   input  logic        cpu_halt,
   input  logic        pipe_flush,
   input  logic        d2e_valid,
   output logic        d2e_rdy,
   input  instr_kind_t kind,
   input  op_code_u    op,
   input  pc_t         pc,
   input  gpr_addr_t   rd_addr,
   input  logic        rd_wr,
   input  pc_t         predicted_addr,
   input  word_t       alu_result,
   exe_addr_if.dst     res,
   output logic        rld_pc_flag,        // Fetch must restart at rld_pc_addr
   output pc_t         rld_pc_addr,
   output logic        e2m_valid,
   input  logic        e2m_rdy,
   output pc_t         e2m_pc,
   output instr_kind_t e2m_kind,
   output logic        e2m_rd_wr,
   output gpr_addr_t   e2m_rd_addr,
   output word_t       e2m_rd_data,
   output logic        e2m_is_ld,
   output logic        e2m_is_st,
   output word_t       e2m_ls_addr,
   output word_t       e2m_st_data,
   output ls_size_t    e2m_size,
   output logic        e2m_zero_ext,
   output logic        e2m_instr_err
);

   logic  xfer_in, xfer_out;
   logic  rd_ok;                           // Rd write, x0 suppressed
   logic  redirect;
   logic  nx_rd_wr, nx_is_ld, nx_is_st, nx_err;
   word_t nx_rd_data;

   assign xfer_out = e2m_valid & e2m_rdy;
   assign d2e_rdy  = rst_n & ~cpu_halt & (~e2m_valid | xfer_out);
   assign xfer_in  = d2e_valid & d2e_rdy;
   assign rd_ok    = rd_wr & (rd_addr != '0);
   assign redirect = (kind == BRANCH) & ~res.br_mis & (res.next_pc != predicted_addr);

   assign rld_pc_flag = d2e_valid & redirect;
   assign rld_pc_addr = res.next_pc;

   // ----------------------------------------------------------------------
   always_comb
   begin
      nx_rd_wr   = 1'b0;
      nx_rd_data = alu_result;
      nx_is_ld   = 1'b0;
      nx_is_st   = 1'b0;
      nx_err     = 1'b0;
      case (kind)
         ALU:     nx_rd_wr = rd_ok;
         BRANCH:
         begin
            nx_err     = res.br_mis;                      // Misaligned target traps later
            nx_rd_wr   = rd_ok & ~res.br_mis & ~redirect & (op.br != B_ADD);
            nx_rd_data = word_t'(res.link_pc);            // Only JAL/JALR write a link
         end
         LOAD:
         begin
            nx_rd_wr = rd_ok;                             // Data arrives in MEM
            nx_is_ld = 1'b1;
            nx_err   = res.ls_mis;
         end
         STORE:
         begin
            nx_is_st = 1'b1;
            nx_err   = res.ls_mis;
         end
         default: nx_err = 1'b1;                          // ILLEGAL
      endcase
   end

   // ----------------------------------------------------------------------
   // Pipe register, one entry
   always_ff @(posedge clk_in)
   begin
      if (!rst_n || pipe_flush)
         e2m_valid <= 1'b0;
      else if (xfer_in)
         e2m_valid <= 1'b1;
      else if (xfer_out)
         e2m_valid <= 1'b0;
   end

   always_ff @(posedge clk_in)
   begin
      if (xfer_in)                                        // Holds under back-pressure
      begin
         e2m_pc        <= pc;
         e2m_kind      <= kind;
         e2m_rd_wr     <= nx_rd_wr;
         e2m_rd_addr   <= rd_addr;
         e2m_rd_data   <= nx_rd_data;
         e2m_is_ld     <= nx_is_ld;
         e2m_is_st     <= nx_is_st;
         e2m_ls_addr   <= res.ls_addr;
         e2m_st_data   <= res.st_data;
         e2m_size      <= res.size;
         e2m_zero_ext  <= res.zero_ext;
         e2m_instr_err <= nx_err;
      end
   end

endmodule

// File: source/execute.sv
// Execute stage top
// RV32I execute: operand forwarding, ALU and address units, result stage
`timescale 1ns/10ps

module execute import exe_pkg::*;
(
   input  logic        clk_in,
   input  logic        rst_n,
   input  logic        cpu_halt,
   input  logic        pipe_flush,

   // Decode side
   input  logic        d2e_valid,
   output logic        d2e_rdy,
   input  instr_kind_t kind,
   input  op_code_u    op,
   input  logic [2:0]  funct3,
   input  pc_t         pc,
   input  word_t       imm,
   input  logic        sel_imm,
   input  gpr_addr_t   rd_addr,
   input  logic        rd_wr,
   input  gpr_addr_t   rs1_addr,
   input  logic        rs1_rd,
   input  gpr_addr_t   rs2_addr,
   input  logic        rs2_rd,
   input  pc_t         predicted_addr,
   input  word_t       gpr_rs1_data,
   input  word_t       gpr_rs2_data,

   // Forwarding sources
   input  logic        fwd_mem_valid,
   input  logic        fwd_mem_rd_wr,
   input  gpr_addr_t   fwd_mem_rd_addr,
   input  word_t       fwd_mem_rd_data,
   input  logic        fwd_wb_valid,
   input  logic        fwd_wb_rd_wr,
   input  gpr_addr_t   fwd_wb_rd_addr,
   input  word_t       fwd_wb_rd_data,

   // PC reload to fetch
   output logic        rld_pc_flag,
   output pc_t         rld_pc_addr,

   // Memory side
   output logic        e2m_valid,
   input  logic        e2m_rdy,
   output pc_t         e2m_pc,
   output instr_kind_t e2m_kind,
   output logic        e2m_rd_wr,
   output gpr_addr_t   e2m_rd_addr,
   output word_t       e2m_rd_data,
   output logic        e2m_is_ld,
   output logic        e2m_is_st,
   output word_t       e2m_ls_addr,
   output word_t       e2m_st_data,
   output ls_size_t    e2m_size,
   output logic        e2m_zero_ext,
   output logic        e2m_instr_err
);

   exe_operand_if opnd_bus();
   exe_addr_if    addr_bus();
   word_t         alu_result;

   exe_operand_fwd u_fwd
   (
      .rs1_addr, .rs2_addr, .rs1_rd, .rs2_rd, .gpr_rs1_data, .gpr_rs2_data,
      .fwd_mem_valid, .fwd_mem_rd_wr, .fwd_mem_rd_addr, .fwd_mem_rd_data,
      .fwd_wb_valid,  .fwd_wb_rd_wr,  .fwd_wb_rd_addr,  .fwd_wb_rd_data,
      .pc, .imm, .sel_imm, .op, .funct3,
      .opnd(opnd_bus)
   );

   // Both units see the same operands in the same cycle
   exe_alu_unit u_alu
   (
      .opnd(opnd_bus),
      .alu_result(alu_result)
   );

   exe_addr_unit u_addr
   (
      .opnd(opnd_bus),
      .kind(kind),
      .res(addr_bus)
   );

   exe_result_sel u_res
   (
      .clk_in, .rst_n, .cpu_halt, .pipe_flush, .d2e_valid, .d2e_rdy,
      .kind, .op, .pc, .rd_addr, .rd_wr, .predicted_addr,
      .alu_result(alu_result),
      .res(addr_bus),
      .rld_pc_flag, .rld_pc_addr,
      .e2m_valid, .e2m_rdy, .e2m_pc, .e2m_kind, .e2m_rd_wr, .e2m_rd_addr, .e2m_rd_data,
      .e2m_is_ld, .e2m_is_st, .e2m_ls_addr, .e2m_st_data, .e2m_size, .e2m_zero_ext,
      .e2m_instr_err
   );

endmodule

// File: dv/tb_clk_gen.sv
// Testbench clock and reset
// Free running clock, synchronous active low reset held for a fixed number of cycles
`timescale 1ns/10ps

module tb_clk_gen
#(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 10
)
(
   output logic clk_in,
   output logic rst_n
);

   initial
   begin
      clk_in = 1'b0;
      forever #(PERIOD_NS / 2) clk_in = ~clk_in;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_in);
      #2 rst_n = 1'b1;                            // Released just after an edge
   end

endmodule

// File: dv/tb_execute.sv
// Execute stage testbench
// Directed tests for the ALU, forwarding, branches, load/store and flow control
`timescale 1ns/10ps

module tb_execute import exe_pkg::*; ();

   localparam int  CLK_NS    = 20;
   localparam int  NUM_TESTS = 6;
   localparam pc_t BR_PC     = 32'h0000_1000;     // Default instruction address

   logic        clk_in;
   logic        rst_n;
   logic        cpu_halt;
   logic        pipe_flush;
   logic        d2e_valid;
   logic        d2e_rdy;
   instr_kind_t kind;
   op_code_u    op;
   logic [2:0]  funct3;
   pc_t         pc;
   word_t       imm;
   logic        sel_imm;
   gpr_addr_t   rd_addr;
   logic        rd_wr;
   gpr_addr_t   rs1_addr;
   logic        rs1_rd;
   gpr_addr_t   rs2_addr;
   logic        rs2_rd;
   pc_t         predicted_addr;
   word_t       gpr_rs1_data;
   word_t       gpr_rs2_data;
   logic        fwd_mem_valid, fwd_mem_rd_wr, fwd_wb_valid, fwd_wb_rd_wr;
   gpr_addr_t   fwd_mem_rd_addr, fwd_wb_rd_addr;
   word_t       fwd_mem_rd_data, fwd_wb_rd_data;
   logic        rld_pc_flag;
   pc_t         rld_pc_addr;
   logic        e2m_valid, e2m_rdy, e2m_rd_wr, e2m_is_ld, e2m_is_st;
   logic        e2m_zero_ext, e2m_instr_err;
   pc_t         e2m_pc;
   instr_kind_t e2m_kind;
   gpr_addr_t   e2m_rd_addr;
   word_t       e2m_rd_data, e2m_ls_addr, e2m_st_data;
   ls_size_t    e2m_size;

   word_t       regs [32];                         // Register file model
   integer      seed;
   logic        got_rld;                           // Reload seen while offered
   pc_t         got_rld_addr;

   assign gpr_rs1_data = regs[rs1_addr];
   assign gpr_rs2_data = regs[rs2_addr];

   tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(10)) u_clk (.clk_in, .rst_n);

   execute dut (.*);

   // ----------------------------------------------------------------------
   // Failure reporting and compares
   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic word_is(input string name, input word_t exp, input word_t act);
      if (exp !== act)
         stop_with_error($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic pc_is(input string name, input pc_t exp, input pc_t act);
      if (exp !== act)
         stop_with_error($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic bit_is(input string name, input logic exp, input logic act);
      if (exp !== act)
         stop_with_error($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic size_is(input string name, input ls_size_t exp, input ls_size_t act);
      if (exp !== act)
         stop_with_error($sformatf("** Error %s: expected %s, actual %s", name,
                                   exp.name(), act.name()));
   endtask

   task automatic kind_is(input string name, input instr_kind_t exp, input instr_kind_t act);
      if (exp !== act)
         stop_with_error($sformatf("** Error %s: expected %s, actual %s", name,
                                   exp.name(), act.name()));
   endtask

   task automatic reg_is(input string name, input gpr_addr_t exp, input gpr_addr_t act);
      if (exp !== act)
         stop_with_error($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
   endtask

   // ----------------------------------------------------------------------
   // Reference rules from the ISA
   function automatic word_t alu_ref(input alu_op_t f, input word_t a, input word_t b,
                                     input word_t i);
      case (f)
         ADD:     return a + b;
         SUB:     return a + ~b + 32'd1;           // Two's complement
         SLL:     return a << b[4:0];
         SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         SLTU:    return (a < b) ? 32'd1 : 32'd0;
         XOR:     return a ^ b;
         SRL:     return a >> b[4:0];
         SRA:     return word_t'($signed(a) >>> b[4:0]);
         OR:      return a | b;
         AND:     return a & b;
         LUI:     return i;
         default: return '0;
      endcase
   endfunction

   function automatic logic br_taken(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return !($signed(a) < $signed(b));   // BGE is not BLT
         3'b110:  return a < b;
         default: return !(a < b);
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Stimulus helpers
   task automatic idle_inputs();
      cpu_halt        = 1'b0;
      pipe_flush      = 1'b0;
      d2e_valid       = 1'b0;
      kind            = ALU;
      op              = '0;
      funct3          = 3'b000;
      pc              = BR_PC;
      imm             = '0;
      sel_imm         = 1'b0;
      rd_addr         = '0;
      rd_wr           = 1'b0;
      rs1_addr        = '0;
      rs1_rd          = 1'b0;
      rs2_addr        = '0;
      rs2_rd          = 1'b0;
      predicted_addr  = '0;
      fwd_mem_valid   = 1'b0;
      fwd_mem_rd_wr   = 1'b0;
      fwd_mem_rd_addr = '0;
      fwd_mem_rd_data = '0;
      fwd_wb_valid    = 1'b0;
      fwd_wb_rd_wr    = 1'b0;
      fwd_wb_rd_addr  = '0;
      fwd_wb_rd_data  = '0;
      e2m_rdy         = 1'b1;
   endtask

   // Next drive point, all inputs back to idle
   task automatic drive_slot();
      @(posedge clk_in);
      #2;
      idle_inputs();
   endtask

   // Offer the instruction, wait for the transfer, check it lands one cycle later
   task automatic send_instr(input string name);
      d2e_valid = 1'b1;
      @(negedge clk_in);
      while (!d2e_rdy)
         @(negedge clk_in);
      got_rld      = rld_pc_flag;
      got_rld_addr = rld_pc_addr;
      @(posedge clk_in);
      #2;
      d2e_valid = 1'b0;
      @(negedge clk_in);
      bit_is({name, " e2m_valid"}, 1'b1, e2m_valid);
      kind_is({name, " kind"}, kind, e2m_kind);
      reg_is({name, " rd_addr"}, rd_addr, e2m_rd_addr);
   endtask

   // ----------------------------------------------------------------------
   // Tests
   task automatic after_reset();
      @(posedge clk_in);                             // First edge clears the pipe register
      @(negedge clk_in);
      bit_is("reset e2m_valid", 1'b0, e2m_valid);
      bit_is("reset d2e_rdy", 1'b0, d2e_rdy);
      bit_is("reset rld_pc_flag", 1'b0, rld_pc_flag);
      wait (rst_n === 1'b1);
      @(negedge clk_in);
      bit_is("released d2e_rdy", 1'b1, d2e_rdy);
   endtask

   task automatic alu_ops();
      alu_op_t f;
      word_t   b;
      string   name;
      for (int i = 0; i <= int'(LUI); i++)
      begin
         for (int s = 0; s < 2; s++)
         begin
            f = alu_op_t'(i);
            name = $sformatf("alu %s sel_imm=%0d", f.name(), s);
            drive_slot();
            regs[5]  = $random(seed);
            regs[6]  = $random(seed);
            imm      = $random(seed);
            b        = (s == 1) ? imm : regs[6];
            kind     = ALU;
            op.alu   = f;
            sel_imm  = s[0];
            rs1_addr = 5'd5;
            rs2_addr = 5'd6;
            rs1_rd   = 1'b1;
            rs2_rd   = 1'b1;
            rd_addr  = gpr_addr_t'(i + 1);
            rd_wr    = 1'b1;
            send_instr(name);
            word_is(name, alu_ref(f, regs[5], b, imm), e2m_rd_data);
            bit_is({name, " rd_wr"}, 1'b1, e2m_rd_wr);
         end
      end
      drive_slot();                                 // x0 destination, no write
      op.alu = ADD;
      rd_wr  = 1'b1;
      send_instr("alu rd x0");
      bit_is("alu rd x0 rd_wr", 1'b0, e2m_rd_wr);
   endtask

   // Same register on both sources, so the sum checks both paths
   task automatic fwd_case(input string name, input gpr_addr_t r, input gpr_addr_t mem_a,
                           input gpr_addr_t wb_a, input logic wr, input word_t exp_opnd);
      drive_slot();
      kind            = ALU;
      op.alu          = ADD;
      rs1_addr        = r;
      rs2_addr        = r;
      rs1_rd          = 1'b1;
      rs2_rd          = 1'b1;
      rd_addr         = 5'd9;
      rd_wr           = 1'b1;
      fwd_mem_valid   = 1'b1;
      fwd_mem_rd_wr   = wr;
      fwd_mem_rd_addr = mem_a;
      fwd_mem_rd_data = 32'h1111_0001;
      fwd_wb_valid    = 1'b1;
      fwd_wb_rd_wr    = wr;
      fwd_wb_rd_addr  = wb_a;
      fwd_wb_rd_data  = 32'h2222_0002;
      send_instr(name);
      word_is(name, exp_opnd + exp_opnd, e2m_rd_data);
   endtask

   task automatic fwd_priority();
      regs[7] = 32'h3333_0003;
      fwd_case("fwd mem over wb", 5'd7, 5'd7, 5'd7, 1'b1, 32'h1111_0001);
      fwd_case("fwd wb only",     5'd7, 5'd8, 5'd7, 1'b1, 32'h2222_0002);
      fwd_case("fwd x0",          5'd0, 5'd0, 5'd0, 1'b1, 32'h0000_0000);
      fwd_case("fwd no rd_wr",    5'd7, 5'd7, 5'd7, 1'b0, 32'h3333_0003);
   endtask

   task automatic branch_case(input string name, input br_op_t bop, input logic [2:0] f3,
                              input word_t a, input word_t b, input word_t offs,
                              input pc_t pred, input pc_t exp_tgt, input logic exp_rld,
                              input logic exp_wr, input logic exp_err);
      drive_slot();
      regs[5]        = a;
      regs[6]        = b;
      kind           = BRANCH;
      op.br          = bop;
      funct3         = f3;
      imm            = offs;
      predicted_addr = pred;
      rs1_addr       = 5'd5;
      rs2_addr       = 5'd6;
      rs1_rd         = 1'b1;
      rs2_rd         = 1'b1;
      rd_addr        = 5'd1;
      rd_wr          = 1'b1;                        // A conditional branch must drop it
      send_instr(name);
      bit_is({name, " reload"}, exp_rld, got_rld);
      if (exp_rld)
         pc_is({name, " target"}, exp_tgt, got_rld_addr);
      bit_is({name, " rd_wr"}, exp_wr, e2m_rd_wr);
      if (exp_wr)
         word_is({name, " link"}, BR_PC + 32'd4, e2m_rd_data);
      bit_is({name, " instr_err"}, exp_err, e2m_instr_err);
   endtask

   task automatic branches();
      logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      word_t      pa [3]  = '{32'hFFFF_FFFD, 32'd5, 32'd7};
      word_t      pb [3]  = '{32'd5, 32'hFFFF_FFFD, 32'd7};
      logic       t;
      for (int i = 0; i < 6; i++)
      begin
         for (int k = 0; k < 3; k++)
         begin
            t = br_taken(f3s[i], pa[k], pb[k]);    // Predicted not taken
            branch_case($sformatf("branch f3=%0d pair=%0d", f3s[i], k), B_ADD, f3s[i],
                        pa[k], pb[k], 32'h40, BR_PC + 32'd4,
                        t ? BR_PC + 32'h40 : BR_PC + 32'd4, t, 1'b0, 1'b0);
         end
      end
      branch_case("jal hit", B_JAL, 3'd0, 0, 0, 32'h100, BR_PC + 32'h100, 0, 0, 1, 0);
      branch_case("jal miss", B_JAL, 3'd0, 0, 0, 32'h100, BR_PC + 32'd4,
                  BR_PC + 32'h100, 1'b1, 1'b0, 1'b0);
      // JALR clears bit 0 of rs1 + imm
      branch_case("jalr hit", B_JALR, 3'd0, 32'h2001, 0, 32'h10,
                  32'h0000_2010, 0, 1'b0, 1'b1, 1'b0);
      branch_case("jalr miss", B_JALR, 3'd0, 32'h2001, 0, 32'h10, BR_PC + 32'd4,
                  32'h0000_2010, 1'b1, 1'b0, 1'b0);
      branch_case("jal misaligned", B_JAL, 3'd0, 0, 0, 32'h102, BR_PC + 32'd4, 0,
                  1'b0, 1'b0, 1'b1);
   endtask

   task automatic ls_case(input string name, input instr_kind_t k, input logic [2:0] f3,
                          input word_t offs, input ls_size_t exp_size, input logic exp_zext,
                          input logic exp_err);
      word_t base;
      base = 32'h8000_0100;
      drive_slot();
      regs[5]  = base;
      regs[6]  = $random(seed);
      kind     = k;
      funct3   = f3;
      imm      = offs;
      rs1_addr = 5'd5;
      rs2_addr = 5'd6;
      rs1_rd   = 1'b1;
      rs2_rd   = (k == STORE);
      rd_addr  = 5'd3;
      rd_wr    = 1'b1;                              // A store must drop it
      send_instr(name);
      word_is({name, " addr"}, base + offs, e2m_ls_addr);
      size_is({name, " size"}, exp_size, e2m_size);
      bit_is({name, " zero_ext"}, exp_zext, e2m_zero_ext);
      bit_is({name, " is_ld"}, (k == LOAD), e2m_is_ld);
      bit_is({name, " is_st"}, (k == STORE), e2m_is_st);
      bit_is({name, " rd_wr"}, (k == LOAD), e2m_rd_wr);
      bit_is({name, " instr_err"}, exp_err, e2m_instr_err);
      if (k == STORE)
         word_is({name, " st_data"}, regs[6], e2m_st_data);
   endtask

   task automatic loads_stores();
      ls_case("lb",  LOAD,  3'b000, 32'd1,        BYTE, 1'b0, 1'b0);
      ls_case("lh",  LOAD,  3'b001, 32'd2,        HALF, 1'b0, 1'b0);
      ls_case("lw",  LOAD,  3'b010, 32'hFFFF_FFFC, WORD, 1'b0, 1'b0);
      ls_case("lbu", LOAD,  3'b100, 32'd3,        BYTE, 1'b1, 1'b0);
      ls_case("lhu", LOAD,  3'b101, 32'd6,        HALF, 1'b1, 1'b0);
      ls_case("sb",  STORE, 3'b000, 32'd5,        BYTE, 1'b0, 1'b0);
      ls_case("sh",  STORE, 3'b001, 32'd2,        HALF, 1'b0, 1'b0);
      ls_case("sw",  STORE, 3'b010, 32'd8,        WORD, 1'b0, 1'b0);
      ls_case("lh odd",   LOAD,  3'b001, 32'd1,   HALF, 1'b0, 1'b1);
      ls_case("sw off 2", STORE, 3'b010, 32'd2,   WORD, 1'b0, 1'b1);
   endtask

   task automatic flow_control();
      drive_slot();                                 // Fill with the sink stalled
      e2m_rdy = 1'b0;
      op.alu  = LUI;
      imm     = 32'hABCD_E000;
      rd_addr = 5'd4;
      rd_wr   = 1'b1;
      send_instr("stall fill");
      word_is("stall fill", 32'hABCD_E000, e2m_rd_data);
      @(posedge clk_in);
      #2;
      imm       = 32'h1234_5000;                    // Second item waits at the input
      pc        = BR_PC + 32'd4;
      d2e_valid = 1'b1;
      repeat (3)
      begin
         @(negedge clk_in);
         bit_is("stall d2e_rdy", 1'b0, d2e_rdy);
         bit_is("stall e2m_valid", 1'b1, e2m_valid);
         word_is("stall rd_data", 32'hABCD_E000, e2m_rd_data);
         pc_is("stall pc", BR_PC, e2m_pc);
      end
      @(posedge clk_in);
      #2;
      e2m_rdy = 1'b1;
      @(negedge clk_in);
      bit_is("drain d2e_rdy", 1'b1, d2e_rdy);        // Emptied and refilled in one edge
      @(posedge clk_in);
      #2;
      d2e_valid = 1'b0;
      @(negedge clk_in);
      bit_is("drain e2m_valid", 1'b1, e2m_valid);
      word_is("drain rd_data", 32'h1234_5000, e2m_rd_data);

      drive_slot();
      cpu_halt  = 1'b1;
      d2e_valid = 1'b1;
      repeat (2)
      begin
         @(negedge clk_in);
         bit_is("halt d2e_rdy", 1'b0, d2e_rdy);
         bit_is("halt e2m_valid", 1'b0, e2m_valid);
      end

      drive_slot();
      e2m_rdy = 1'b0;
      op.alu  = LUI;
      imm     = 32'h5555_0000;
      send_instr("flush fill");
      @(posedge clk_in);
      #2;
      pipe_flush = 1'b1;
      @(negedge clk_in);
      bit_is("flush before edge", 1'b1, e2m_valid);
      @(posedge clk_in);
      #2;
      pipe_flush = 1'b0;
      @(negedge clk_in);
      bit_is("flush e2m_valid", 1'b0, e2m_valid);
      drive_slot();
   endtask

   // ----------------------------------------------------------------------
   initial
   begin
      int r;
      seed = 43;
      for (r = 0; r < 32; r++)
         regs[r] = {r[7:0], ~r[7:0], r[7:0] ^ 8'h5A, r[7:0] ^ 8'hC3};
      regs[0] = '0;                                  // x0 reads as zero
      idle_inputs();
      after_reset();
      alu_ops();
      fwd_priority();
      branches();
      loads_stores();
      flow_control();
      $display("Simulation PASSED");
      $finish;
   end

   // Watchdog, 200 cycles per test
   initial
   begin
      #(NUM_TESTS * 200 * CLK_NS);
      $display("Simulation FAILED");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", NUM_TESTS * 200);
   end

endmodule

// File: all.f
+incdir+source
source/exe_pkg.sv
source/exe_operand_if.sv
source/exe_addr_if.sv
source/exe_operand_fwd.sv
source/exe_alu_unit.sv
source/exe_addr_unit.sv
source/exe_result_sel.sv
source/execute.sv
dv/tb_clk_gen.sv
dv/tb_execute.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/10ps

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
